/* common/sad_pkg.sv */
package sad_pkg;

    // stream and reference geometry
    localparam int REF_SAMPLES    = 32;   // reference length, also number of window positions
    localparam int SAMPLE_BITS    = 8;
    localparam int SADS_PER_CYCLE = 2;    // samples entering per clock
    localparam int NUM_PAIRS      = REF_SAMPLES / SADS_PER_CYCLE;
    localparam int POS_WIDTH      = $clog2(REF_SAMPLES);

    // accumulator width, msb set means saturated
    localparam int SAD_WIDTH      = 16;

    // register port
    localparam int BYTECNT_WIDTH  = 7;

    localparam logic [7:0] ADDR_REFERENCE         = 8'h10;  // byte k is sample k
    localparam logic [7:0] ADDR_REFEN             = 8'h11;
    localparam logic [7:0] ADDR_THRESHOLD         = 8'h12;  // read back as 32 bits
    localparam logic [7:0] ADDR_STATUS            = 8'h13;  // write clears
    localparam logic [7:0] ADDR_MULTIPLE_TRIGGERS = 8'h14;
    localparam logic [7:0] ADDR_ALWAYS_ARMED      = 8'h15;
    localparam logic [7:0] ADDR_REF_SAMPLES       = 8'h16;  // read only

    // status word layout, count is little endian
    localparam int STATUS_FLAG_BYTE  = 0;
    localparam int STATUS_COUNT_BYTE = 1;

endpackage

/* sad_core/sad_frame_sequencer.sv */
`timescale 1ns/10ps

module sad_frame_sequencer
    import sad_pkg::*;
(
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic [SAMPLE_BITS-1:0] adc_datain,
    input  logic                   armed_and_ready,
    input  logic                   active,
    input  logic                   xadc_error,
    input  logic                   always_armed,
    output logic                   run,
    output logic                   arm_start,
    output logic [POS_WIDTH-1:0]   position,
    output logic                   tick_tock,
    output logic [SAMPLE_BITS-1:0] datain_a,
    output logic [SAMPLE_BITS-1:0] datain_b,
    output logic [SAMPLE_BITS-1:0] datain_a_pos,
    output logic [SAMPLE_BITS-1:0] datain_a_neg,
    output logic [SAMPLE_BITS-1:0] datain_b_pos,
    output logic [SAMPLE_BITS-1:0] datain_b_neg,
    output logic [REF_SAMPLES-1:0] resetter,
    output logic [REF_SAMPLES-1:0] ready
);

    logic [SAMPLE_BITS-1:0] adc_datain_r;
    logic [POS_WIDTH-1:0]   pos_count;      // full position, lsb is the phase
    logic                   armed_and_ready_r;

    assign run       = (armed_and_ready || always_armed) && active && !xadc_error;
    assign position  = {pos_count[POS_WIDTH-1:1], 1'b0};  // even slot of current pair
    assign tick_tock = pos_count[0];

    // a is the older sample of each pair, b the newer
    always_ff @(posedge adc_sampleclk) begin
        adc_datain_r <= adc_datain;
        datain_b     <= adc_datain;
        datain_a     <= adc_datain_r;
        datain_a_pos <= datain_a;
        datain_a_neg <= -datain_a;    // two's complement, saves a subtractor later
        datain_b_pos <= datain_b;
        datain_b_neg <= -datain_b;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            armed_and_ready_r <= 1'b0;
            arm_start         <= 1'b0;
        end else begin
            armed_and_ready_r <= armed_and_ready;
            arm_start         <= armed_and_ready && !armed_and_ready_r;
        end
    end

    // window bookkeeping restarts whenever run drops
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            pos_count <= '0;
            resetter  <= REF_SAMPLES'(1) << (REF_SAMPLES - SADS_PER_CYCLE - 1);
            ready     <= '0;
        end else begin
            pos_count <= (pos_count == POS_WIDTH'(REF_SAMPLES - 1)) ? '0 : pos_count + 1'b1;
            resetter  <= {resetter[REF_SAMPLES-2:0], resetter[REF_SAMPLES-1]};  // rotate
            ready     <= {ready[REF_SAMPLES-2:0],
                          ready[0] | (position == POS_WIDTH'(REF_SAMPLES - SADS_PER_CYCLE))};
        end
    end

    // exactly one window closes per cycle and it follows pos_count
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        $onehot(resetter) &&
        resetter[pos_count + POS_WIDTH'(REF_SAMPLES - SADS_PER_CYCLE - 1)]);

endmodule

/* sad_core/sad_pair_diff.sv */
`timescale 1ns/10ps

module sad_pair_diff
    import sad_pkg::*;
(
    input  logic                               adc_sampleclk,
    input  logic                               reset,
    input  logic [REF_SAMPLES*SAMPLE_BITS-1:0] ref_samples,
    input  logic [REF_SAMPLES-1:0]             ref_enable,
    input  logic [POS_WIDTH-1:0]               position,
    input  logic                               tick_tock,
    input  logic [SAMPLE_BITS-1:0]             datain_a,
    input  logic [SAMPLE_BITS-1:0]             datain_b,
    input  logic [SAMPLE_BITS-1:0]             datain_a_pos,
    input  logic [SAMPLE_BITS-1:0]             datain_a_neg,
    input  logic [SAMPLE_BITS-1:0]             datain_b_pos,
    input  logic [SAMPLE_BITS-1:0]             datain_b_neg,
    output logic [NUM_PAIRS-1:0][SAMPLE_BITS:0] counter_incr
);

    logic [SAMPLE_BITS-1:0] ref_a   [NUM_PAIRS];
    logic [SAMPLE_BITS-1:0] ref_b   [NUM_PAIRS];
    logic [SAMPLE_BITS-1:0] ref_a_r [NUM_PAIRS];
    logic [SAMPLE_BITS-1:0] ref_b_r [NUM_PAIRS];
    logic [NUM_PAIRS-1:0]   en_a, en_b, en_a_r, en_b_r;
    logic [NUM_PAIRS-1:0]   above_a, above_b;   // sample greater than its reference
    logic [POS_WIDTH-1:0]   pos_odd;

    assign pos_odd = {position[POS_WIDTH-1:1], 1'b1};

    // |sample - ref| from the precomputed +/- sample, zero when masked
    function automatic logic [SAMPLE_BITS:0] abs_term(
        input logic                   above,
        input logic                   en,
        input logic [SAMPLE_BITS-1:0] s_pos,
        input logic [SAMPLE_BITS-1:0] s_neg,
        input logic [SAMPLE_BITS-1:0] ref_s
    );
        logic [SAMPLE_BITS-1:0] diff;
        diff = above ? s_pos - ref_s : s_neg + ref_s;
        return en ? {1'b0, diff} : '0;
    endfunction

    always_ff @(posedge adc_sampleclk) begin
        ref_a[0] <= ref_samples[position*SAMPLE_BITS +: SAMPLE_BITS];
        ref_b[0] <= ref_samples[pos_odd*SAMPLE_BITS +: SAMPLE_BITS];
        for (int k = 1; k < NUM_PAIRS; k++) begin
            if (!tick_tock) begin   // move down the chain once per pair
                ref_a[k] <= ref_a[k-1];
                ref_b[k] <= ref_b[k-1];
            end
        end
        ref_a_r <= ref_a;
        ref_b_r <= ref_b;
        for (int k = 0; k < NUM_PAIRS; k++) begin
            above_a[k] <= datain_a > ref_a[k];
            above_b[k] <= datain_b > ref_b[k];
            counter_incr[k] <= abs_term(above_a[k], en_a_r[k], datain_a_pos, datain_a_neg,
                                        ref_a_r[k])
                             + abs_term(above_b[k], en_b_r[k], datain_b_pos, datain_b_neg,
                                        ref_b_r[k]);
        end
    end

    // enables follow the same path as the reference samples
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            en_a   <= '0;
            en_b   <= '0;
            en_a_r <= '0;
            en_b_r <= '0;
        end else begin
            en_a[0] <= ref_enable[position];
            en_b[0] <= ref_enable[pos_odd];
            if (!tick_tock) begin
                en_a[NUM_PAIRS-1:1] <= en_a[NUM_PAIRS-2:0];
                en_b[NUM_PAIRS-1:1] <= en_b[NUM_PAIRS-2:0];
            end
            en_a_r <= en_a;
            en_b_r <= en_b;
        end
    end

    for (genvar k = 0; k < NUM_PAIRS; k++) begin : g_mask_chk
        assert property (@(posedge adc_sampleclk) disable iff (reset)
            !en_a_r[k] && !en_b_r[k] |=> counter_incr[k] == '0);
    end

endmodule

/* sad_core/sad_accumulators.sv */
`timescale 1ns/10ps

module sad_accumulators
    import sad_pkg::*;
(
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic [NUM_PAIRS-1:0][SAMPLE_BITS:0] counter_incr,
    input  logic [REF_SAMPLES-1:0]              resetter,
    input  logic [REF_SAMPLES-1:0]              ready,
    input  logic                                tick_tock,
    input  logic [SAD_WIDTH-1:0]                threshold,
    output logic [REF_SAMPLES-1:0]              individual_match
);

    logic [SAD_WIDTH-1:0] sad_count [REF_SAMPLES];

    // two positions share one pair increment, each takes it on its own phase
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            sad_count        <= '{default: '0};
            individual_match <= '0;
        end else begin
            for (int j = 0; j < REF_SAMPLES; j++) begin
                if (resetter[j]) begin
                    // start of a new window
                    sad_count[j] <= SAD_WIDTH'(counter_incr[j/SADS_PER_CYCLE]);
                end else if ((tick_tock ^ j[0]) && !sad_count[j][SAD_WIDTH-1]) begin
                    sad_count[j] <= sad_count[j] + SAD_WIDTH'(counter_incr[j/SADS_PER_CYCLE]);
                end
                // compare the finished count just as the window closes
                individual_match[j] <= resetter[j] && ready[j] && (sad_count[j] <= threshold);
            end
        end
    end

    // headroom below 2**SAD_WIDTH keeps a saturated count from wrapping
    for (genvar j = 0; j < REF_SAMPLES; j++) begin : g_sat_chk
        assert property (@(posedge adc_sampleclk) disable iff (reset)
            sad_count[j][SAD_WIDTH-1] && !resetter[j] |=> sad_count[j][SAD_WIDTH-1]);
    end

endmodule

/* rtl/sad_regs.sv */
`timescale 1ns/10ps

module sad_regs
    import sad_pkg::*;
(
    input  logic                               adc_sampleclk,
    input  logic                               reset,
    input  logic [7:0]                         reg_address,
    input  logic [BYTECNT_WIDTH-1:0]           reg_bytecnt,
    input  logic [7:0]                         reg_datai,
    input  logic                               reg_read,
    input  logic                               reg_write,
    input  logic                               triggered,
    input  logic [15:0]                        num_triggers,
    output logic [7:0]                         reg_datao,
    output logic [REF_SAMPLES*SAMPLE_BITS-1:0] ref_samples,
    output logic [REF_SAMPLES-1:0]             ref_enable,
    output logic [SAD_WIDTH-1:0]               threshold,
    output logic                               multiple_triggers,
    output logic                               always_armed,
    output logic                               clear_status
);

    logic [31:0] threshold_wide;
    logic [23:0] status_word;
    logic [15:0] ref_count_word;

    assign threshold_wide = 32'(threshold);  // host always sees a 32 bit threshold
    assign ref_count_word = 16'(REF_SAMPLES);

    always_comb begin
        status_word = '0;
        status_word[STATUS_FLAG_BYTE*8] = triggered;
        status_word[STATUS_COUNT_BYTE*8 +: 16] = num_triggers;
    end

    // writes
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_samples       <= '0;
            ref_enable        <= '1;  // every sample compared by default
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            always_armed      <= 1'b0;
            clear_status      <= 1'b0;
        end else begin
            clear_status <= reg_write && (reg_address == ADDR_STATUS);
            if (reg_write) begin
                case (reg_address)
                    ADDR_REFERENCE:
                        if (reg_bytecnt < REF_SAMPLES)
                            ref_samples[reg_bytecnt*8 +: 8] <= reg_datai;
                    ADDR_REFEN:
                        if (reg_bytecnt < REF_SAMPLES/8)
                            ref_enable[reg_bytecnt*8 +: 8] <= reg_datai;
                    ADDR_THRESHOLD:
                        if (reg_bytecnt < SAD_WIDTH/8)
                            threshold[reg_bytecnt*8 +: 8] <= reg_datai;
                    ADDR_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    ADDR_ALWAYS_ARMED:      always_armed <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // reads, out of range bytes return zero
    always_comb begin
        reg_datao = '0;
        if (reg_read) begin
            case (reg_address)
                ADDR_REFERENCE:
                    if (reg_bytecnt < REF_SAMPLES)
                        reg_datao = ref_samples[reg_bytecnt*8 +: 8];
                ADDR_REFEN:
                    if (reg_bytecnt < REF_SAMPLES/8)
                        reg_datao = ref_enable[reg_bytecnt*8 +: 8];
                ADDR_THRESHOLD:
                    if (reg_bytecnt < 4)
                        reg_datao = threshold_wide[reg_bytecnt*8 +: 8];
                ADDR_STATUS:
                    if (reg_bytecnt < 3)
                        reg_datao = status_word[reg_bytecnt*8 +: 8];
                ADDR_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                ADDR_ALWAYS_ARMED:      reg_datao = {7'b0, always_armed};
                ADDR_REF_SAMPLES:
                    if (reg_bytecnt < 2)
                        reg_datao = ref_count_word[reg_bytecnt*8 +: 8];
                default: ;
            endcase
        end
    end

endmodule

/* rtl/sad_trigger_ctrl.sv */
`timescale 1ns/10ps

module sad_trigger_ctrl
    import sad_pkg::*;
(
    input  logic                   adc_sampleclk,
    input  logic                   reset,
    input  logic [REF_SAMPLES-1:0] individual_match,
    input  logic                   multiple_triggers,
    input  logic                   clear_status,
    input  logic                   arm_start,
    output logic                   trigger,
    output logic                   triggered,
    output logic [15:0]            num_triggers
);

    logic trigger_r;
    logic blocked;

    assign blocked = triggered && !multiple_triggers;  // one shot until cleared

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger      <= 1'b0;
            trigger_r    <= 1'b0;
            triggered    <= 1'b0;
            num_triggers <= '0;
        end else begin
            trigger   <= |individual_match && !blocked;
            trigger_r <= trigger;
            if (clear_status || arm_start) begin
                triggered    <= 1'b0;
                num_triggers <= '0;
            end else if (trigger && !trigger_r) begin   // count rising edges only
                triggered    <= 1'b1;
                num_triggers <= num_triggers + 1'b1;
            end
        end
    end

    assert property (@(posedge adc_sampleclk) disable iff (reset)
        blocked |=> !trigger);

endmodule

/* rtl/sad_trigger.sv */
`timescale 1ns/10ps

module sad_trigger
    import sad_pkg::*;
(
    input  logic                     adc_sampleclk,
    input  logic                     reset,
    input  logic                     xadc_error,
    input  logic [SAMPLE_BITS-1:0]   adc_datain,
    input  logic                     armed_and_ready,
    input  logic                     active,
    input  logic [7:0]               reg_address,
    input  logic [BYTECNT_WIDTH-1:0] reg_bytecnt,
    input  logic [7:0]               reg_datai,
    input  logic                     reg_read,
    input  logic                     reg_write,
    output logic [7:0]               reg_datao,
    output logic                     trigger
);

    // configuration and status
    logic [REF_SAMPLES*SAMPLE_BITS-1:0]  ref_samples;
    logic [REF_SAMPLES-1:0]              ref_enable;
    logic [SAD_WIDTH-1:0]                threshold;
    logic                                multiple_triggers;
    logic                                always_armed;
    logic                                clear_status;
    logic                                triggered;
    logic [15:0]                         num_triggers;

    // datapath
    logic                                arm_start;
    logic [POS_WIDTH-1:0]                position;
    logic                                tick_tock;
    logic [SAMPLE_BITS-1:0]              datain_a, datain_b;
    logic [SAMPLE_BITS-1:0]              datain_a_pos, datain_a_neg;
    logic [SAMPLE_BITS-1:0]              datain_b_pos, datain_b_neg;
    logic [REF_SAMPLES-1:0]              resetter;
    logic [REF_SAMPLES-1:0]              ready;
    logic [NUM_PAIRS-1:0][SAMPLE_BITS:0] counter_incr;
    logic [REF_SAMPLES-1:0]              individual_match;

    sad_regs u_regs (.*);

    sad_frame_sequencer u_sequencer (
        .*,
        .run ()     // qualifier only needed inside the sequencer
    );

    sad_pair_diff u_pair_diff (.*);

    sad_accumulators u_accumulators (.*);

    sad_trigger_ctrl u_trigger_ctrl (.*);

endmodule

/* bench/sad_tb_tasks.svh */
// one clock step, inputs change just after the rising edge
task automatic tick();
    @(posedge adc_sampleclk);
    #1;
    reg_write  = 1'b0;
    reg_read   = 1'b0;
    adc_datain = 8'($random(seed));  // filler, not scored by the model
endtask

task automatic write_reg(input logic [7:0] addr, input int byte_idx, input logic [7:0] data);
    tick();
    reg_address = addr;
    reg_bytecnt = BYTECNT_WIDTH'(byte_idx);
    reg_datai   = data;
    reg_write   = 1'b1;
endtask

// reg_datao is combinational, sampled mid cycle
task automatic read_reg(input logic [7:0] addr, input int byte_idx, output logic [7:0] data);
    tick();
    reg_address = addr;
    reg_bytecnt = BYTECNT_WIDTH'(byte_idx);
    reg_read    = 1'b1;
    @(negedge adc_sampleclk);
    data = reg_datao;
endtask

task automatic send_sample(input logic [7:0] sample);
    tick();
    adc_datain = sample;
    stream.push_back(sample);
endtask

task automatic send_filler(input int count);
    repeat (count) send_sample(8'($random(seed)));
endtask

// windows of the scored stream whose masked SAD is within thr, oldest vs ref 0
function automatic int count_matches(input logic [SAD_WIDTH-1:0] thr);
    int hits;
    int sad;
    int diff;
    hits = 0;
    for (int i = 0; i + REF_SAMPLES <= stream.size(); i++) begin
        sad = 0;
        for (int k = 0; k < REF_SAMPLES; k++) begin
            diff = int'(stream[i+k]) - int'(ref_bytes[k]);
            if (ref_mask[k])
                sad += (diff < 0) ? -diff : diff;
        end
        if (sad <= int'(thr))
            hits++;
    end
    return hits;
endfunction

/* bench/sad_trigger_tb.sv */
`timescale 1ns/10ps

module sad_trigger_tb
    import sad_pkg::*;
();

    localparam int CLK_PERIOD     = 4;
    localparam int NUM_ROWS       = 10;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * 400;  // rows, readback and re-arm

    typedef struct packed {
        logic [31:0] ref_seed;
        logic [31:0] enable;
        logic [15:0] threshold;
        logic        multiple;
        logic        always_armed;
        logic        armed;
        logic        adc_err;
        logic [1:0]  copies;
        logic [7:0]  bad_pos0;
        logic [7:0]  bad_amt0;
        logic [7:0]  bad_pos1;
        logic [7:0]  bad_amt1;
        logic        exp_triggered;
        logic [15:0] exp_count;
    } row_t;

    logic                     adc_sampleclk = 1'b0;
    logic                     reset;
    logic                     xadc_error;
    logic [SAMPLE_BITS-1:0]   adc_datain;
    logic                     armed_and_ready;
    logic                     active;
    logic [7:0]               reg_address;
    logic [BYTECNT_WIDTH-1:0] reg_bytecnt;
    logic [7:0]               reg_datai;
    logic                     reg_read;
    logic                     reg_write;
    logic [7:0]               reg_datao;
    logic                     trigger;

    int                       seed = 63676;
    logic [7:0]               stream [$];     // samples the model scores
    logic [7:0]               ref_bytes [REF_SAMPLES];
    logic [REF_SAMPLES-1:0]   ref_mask;
    int                       trigger_pulses = 0;   // trigger pulses seen in this row
    logic                     trigger_seen = 1'b0;

    // seed, mask, thr, mult, always, armed, err, copies, pos/amt x2, exp flag, exp count
    row_t tests [NUM_ROWS] = '{
        '{101, 32'hffff_ffff, 0,  0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 1},   // exact copy
        '{202, 32'hffff_ffff, 35, 0, 0, 1, 0, 1, 3, 20, 17, 15, 1, 1}, // D = 35
        '{202, 32'hffff_ffff, 34, 0, 0, 1, 0, 1, 3, 20, 17, 15, 0, 0},
        '{202, 32'hfffd_fff7, 0,  0, 0, 1, 0, 1, 3, 20, 17, 15, 1, 1}, // bad samples masked
        '{101, 32'hffff_ffff, 0,  0, 0, 1, 0, 2, 0, 0, 0, 0, 1, 1},
        '{101, 32'hffff_ffff, 0,  1, 0, 1, 0, 2, 0, 0, 0, 0, 1, 2},
        '{303, 32'hffff_ffff, 0,  0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0},   // not armed
        '{303, 32'hffff_ffff, 0,  0, 1, 0, 0, 1, 0, 0, 0, 0, 1, 1},
        '{303, 32'hffff_ffff, 0,  0, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0},   // adc error
        '{404, 32'hffff_ffff, 0,  0, 0, 1, 0, 1, 0, 0, 0, 0, 1, 1}
    };

    `include "sad_tb_tasks.svh"

    sad_trigger UUT (.*);

    always #(CLK_PERIOD/2) adc_sampleclk = ~adc_sampleclk;

    // rising edges of trigger, looked at mid cycle
    always @(negedge adc_sampleclk) begin
        if (trigger === 1'b1 && trigger_seen !== 1'b1)
            trigger_pulses++;
        trigger_seen = trigger;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, expected);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic set_arm(input logic level, input logic err);
        tick();
        armed_and_ready = level;
        xadc_error      = err;
    endtask

    task automatic read_status(output logic [7:0] flag_byte, output logic [15:0] count);
        logic [7:0] lo;
        logic [7:0] hi;
        read_reg(ADDR_STATUS, STATUS_FLAG_BYTE, flag_byte);
        read_reg(ADDR_STATUS, STATUS_COUNT_BYTE, lo);
        read_reg(ADDR_STATUS, STATUS_COUNT_BYTE + 1, hi);
        count = {hi, lo};
    endtask

    // shift a sample by amt away from the nearer rail, so |change| is exactly amt
    function automatic logic [7:0] nudge(input logic [7:0] b, input logic [7:0] amt);
        return (b < 8'd128) ? b + amt : b - amt;
    endfunction

    initial begin
        row_t        tst;
        logic [7:0]  rd;
        logic [7:0]  flag;
        logic [15:0] count;
        logic [7:0]  written [REF_SAMPLES];
        logic [7:0]  pattern [REF_SAMPLES];
        int          ref_seed;
        int          hits;
        int          expected;
        logic        run_ok;

        reset = 1'b1;
        xadc_error = 1'b0;
        adc_datain = '0;
        armed_and_ready = 1'b0;
        active = 1'b0;       // keep the matcher idle during readback
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai = '0;
        reg_read = 1'b0;
        reg_write = 1'b0;
        repeat (4) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;

        for (int k = 0; k < REF_SAMPLES; k++) begin
            written[k] = 8'($random(seed));
            write_reg(ADDR_REFERENCE, k, written[k]);
        end
        for (int n = 0; n < REF_SAMPLES/8; n++)
            write_reg(ADDR_REFEN, n, 8'h5a ^ 8'(n * 17));
        write_reg(ADDR_THRESHOLD, 0, 8'h34);
        write_reg(ADDR_THRESHOLD, 1, 8'h12);
        write_reg(ADDR_MULTIPLE_TRIGGERS, 0, 8'h01);
        write_reg(ADDR_ALWAYS_ARMED, 0, 8'h01);
        for (int k = 0; k < REF_SAMPLES; k++) begin
            read_reg(ADDR_REFERENCE, k, rd);
            check_value($sformatf("reference[%0d]", k), rd, written[k]);
        end
        for (int n = 0; n < REF_SAMPLES/8; n++) begin
            read_reg(ADDR_REFEN, n, rd);
            check_value($sformatf("ref_enable byte %0d", n), rd, 8'h5a ^ 8'(n * 17));
        end
        for (int n = 0; n < 4; n++) begin
            read_reg(ADDR_THRESHOLD, n, rd);
            check_value($sformatf("threshold byte %0d", n), rd, 8'(32'h1234 >> (n * 8)));
        end
        read_reg(ADDR_MULTIPLE_TRIGGERS, 0, rd);
        check_value("multiple_triggers", rd, 1);
        read_reg(ADDR_ALWAYS_ARMED, 0, rd);
        check_value("always_armed", rd, 1);
        read_reg(ADDR_REF_SAMPLES, 0, rd);
        check_value("ref samples low byte", rd, REF_SAMPLES % 256);
        read_reg(ADDR_REF_SAMPLES, 1, rd);
        check_value("ref samples high byte", rd, REF_SAMPLES / 256);
        active = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            tst = tests[r];
            set_arm(1'b0, tst.adc_err);
            trigger_pulses = 0;
            write_reg(ADDR_THRESHOLD, 0, tst.threshold[7:0]);
            write_reg(ADDR_THRESHOLD, 1, tst.threshold[15:8]);
            write_reg(ADDR_MULTIPLE_TRIGGERS, 0, {7'b0, tst.multiple});
            write_reg(ADDR_ALWAYS_ARMED, 0, {7'b0, tst.always_armed});
            write_reg(ADDR_STATUS, 0, 8'h00);      // drops the previous row's result
            ref_seed = tst.ref_seed;
            for (int k = 0; k < REF_SAMPLES; k++) begin
                ref_bytes[k] = 8'($random(ref_seed));
                write_reg(ADDR_REFERENCE, k, ref_bytes[k]);
            end
            ref_mask = tst.enable;
            for (int n = 0; n < REF_SAMPLES/8; n++)
                write_reg(ADDR_REFEN, n, ref_mask[n*8 +: 8]);
            read_status(flag, count);
            check_value($sformatf("triggered after clear (row %0d)", r), flag, 0);
            check_value($sformatf("num_triggers after clear (row %0d)", r), count, 0);

            set_arm(tst.armed, tst.adc_err);
            stream.delete();
            send_filler(64);                       // one full pass before any copy
            for (int k = 0; k < REF_SAMPLES; k++)
                pattern[k] = ref_bytes[k];
            if (tst.bad_amt0 != 0)
                pattern[tst.bad_pos0] = nudge(ref_bytes[tst.bad_pos0], tst.bad_amt0);
            if (tst.bad_amt1 != 0)
                pattern[tst.bad_pos1] = nudge(ref_bytes[tst.bad_pos1], tst.bad_amt1);
            repeat (tst.copies) begin
                for (int k = 0; k < REF_SAMPLES; k++)
                    send_sample(pattern[k]);
                send_filler(64);
            end
            send_filler(60);                       // pipeline drains here
            read_status(flag, count);

            hits = count_matches(tst.threshold);
            run_ok = (tst.armed || tst.always_armed) && !tst.adc_err;
            expected = !run_ok ? 0 : (tst.multiple ? hits : (hits > 0 ? 1 : 0));
            assert (expected == int'(tst.exp_count)) else begin
                $display("row %0d: the model predicts %0d triggers but the table expects %0d",
                         r, expected, tst.exp_count);
                $display("RESULT: FAIL");
                $fatal(1);
            end
            check_value($sformatf("triggered (row %0d)", r), flag, {7'b0, tst.exp_triggered});
            check_value($sformatf("num_triggers (row %0d)", r), count, tst.exp_count);
            check_value($sformatf("trigger pulses (row %0d)", r), trigger_pulses,
                        tst.exp_count);
        end

        // last row left triggered set, a new arm edge must clear it
        set_arm(1'b0, 1'b0);
        set_arm(1'b1, 1'b0);
        tick();
        tick();
        read_status(flag, count);
        check_value("triggered after re-arm", flag, 0);
        check_value("num_triggers after re-arm", count, 0);

        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("simulation timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1);
    end

endmodule

/* sad_trigger.f */
+incdir+bench
common/sad_pkg.sv
sad_core/sad_frame_sequencer.sv
sad_core/sad_pair_diff.sv
sad_core/sad_accumulators.sv
rtl/sad_regs.sv
rtl/sad_trigger_ctrl.sv
rtl/sad_trigger.sv
bench/sad_trigger_tb.sv
